//--- hw/cdc_fifo_pkg.sv
/*
 * Shared sizes and types for the dual-clock FIFO.
 * Every RTL module refers to these by scoped name, e.g. cdc_fifo_pkg::pointer_t.
 * Depth is a power of two so the binary pointers wrap naturally.
 */
package cdc_fifo_pkg;

    // Stream word size
    localparam int DATA_WIDTH = 8;

    // Pointer width sets the memory depth
    localparam int ADDRESS_WIDTH = 4;
    localparam int DEPTH = 2 ** ADDRESS_WIDTH;

    // Write side accepts only while the registered fill estimate is below this
    // Margin covers the registered difference and the registered ready
    localparam int ALMOST_FULL = DEPTH - 3;

    // Read and write pointers, also used as memory addresses
    typedef logic [ADDRESS_WIDTH-1:0] pointer_t;

    // One memory write from the write controller
    typedef struct packed {
        logic                  enable;  // Store data this cycle
        logic [DATA_WIDTH-1:0] data;    // Word to store
        pointer_t              pointer; // Target slot
    } write_request_t;

endpackage

//--- hw/cdc_fifo_write.sv
/*
 * Write-domain controller of the dual-clock FIFO.
 * Accepts words on the rx valid/ready pair and turns each one into a
 * registered memory write request. Ready is throttled from a registered
 * fill estimate so that words still in the pipeline always find a free slot.
 */
`timescale 1ns/1ps

module cdc_fifo_write (
    input  logic                                rx_aclk,
    input  logic                                rx_areset_n,
    // Incoming stream
    input  logic                                rx_tvalid,
    input  logic [cdc_fifo_pkg::DATA_WIDTH-1:0] rx_tdata,
    output logic                                rx_tready,
    // Memory side
    output cdc_fifo_pkg::write_request_t        write_request,
    output cdc_fifo_pkg::pointer_t              write_pointer,
    input  cdc_fifo_pkg::pointer_t              read_pointer_synced
);

    cdc_fifo_pkg::pointer_t difference;      // Registered fill estimate
    cdc_fifo_pkg::pointer_t pending_pointer; // Write pointer with request in flight counted

    logic                                request_enable;
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] request_data;
    cdc_fifo_pkg::pointer_t              request_pointer;

    // A request issued last cycle already owns the slot at write_pointer
    assign pending_pointer = write_pointer + cdc_fifo_pkg::pointer_t'(request_enable);

    // Stale read pointer only makes the estimate larger, so this stays safe
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            difference <= '0;
        end else begin
            difference <= pending_pointer - read_pointer_synced;
        end
    end

    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            rx_tready <= 1'b0;     // Not ready out of reset
        end else begin
            rx_tready <= (difference < cdc_fifo_pkg::pointer_t'(cdc_fifo_pkg::ALMOST_FULL));
        end
    end

    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            request_enable <= 1'b0;
        end else begin
            request_enable <= rx_tvalid && rx_tready; // One write per accepted word
        end
    end

    // Payload follows the handshake, qualified by request_enable
    always_ff @(posedge rx_aclk) begin
        request_data    <= rx_tdata;
        request_pointer <= pending_pointer; // Next free slot even on back-to-back accepts
    end

    // Pointer moves on the edge where the memory stores the word
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            write_pointer <= '0;
        end else if (request_enable) begin
            write_pointer <= write_pointer + 1'b1;
        end
    end

    assign write_request = '{
        enable:  request_enable,
        data:    request_data,
        pointer: request_pointer
    };

endmodule

//--- hw/cdc_fifo_read.sv
/*
 * Read-domain controller of the dual-clock FIFO.
 * Compares the read pointer with the synchronized write pointer, fetches the
 * next word from memory into the tx output register and advances the read
 * pointer. The register reloads in the cycle it is consumed, so a steady
 * stream moves one word per tx cycle.
 */
`timescale 1ns/1ps

module cdc_fifo_read (
    input  logic                                tx_aclk,
    input  logic                                tx_areset_n,
    // Outgoing stream
    output logic                                tx_tvalid,
    output logic [cdc_fifo_pkg::DATA_WIDTH-1:0] tx_tdata,
    input  logic                                tx_tready,
    // Memory side
    output cdc_fifo_pkg::pointer_t              read_pointer,
    input  logic [cdc_fifo_pkg::DATA_WIDTH-1:0] read_data,
    input  cdc_fifo_pkg::pointer_t              write_pointer_synced
);

    logic word_available; // FIFO holds a word not yet in the output register
    logic register_free;  // Output register empty or emptied this cycle
    logic load;           // Move one word from memory to the output register

    // Equal pointers mean empty, the writer never lets the FIFO wrap to full
    assign word_available = (read_pointer != write_pointer_synced);
    assign register_free  = !tx_tvalid || tx_tready;
    assign load           = word_available && register_free;

    // Output valid
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            tx_tvalid <= 1'b0;
        end else if (register_free) begin
            tx_tvalid <= word_available; // Falls only once the last word is taken
        end
    end

    // Output data, held while the consumer stalls
    always_ff @(posedge tx_aclk) begin
        if (load) begin
            tx_tdata <= read_data;
        end
    end

    /*
     * Slot is released to the writer only after its word sits in tx_tdata,
     * and the writer sees that through the synchronizer a few cycles later
     */
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            read_pointer <= '0;
        end else if (load) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end

endmodule

//--- hw/cdc_fifo_pointer_sync.sv
/*
 * Carries a FIFO pointer from one clock domain into another.
 * The pointer is Gray-encoded in a source-clock register, sampled by two
 * destination-clock flops and decoded back to binary. One bit changes per
 * increment, so a sample caught mid-change reads as the old or new value.
 */
`timescale 1ns/1ps

module cdc_fifo_pointer_sync (
    input  logic                   source_aclk,
    input  logic                   source_areset_n,
    input  logic                   destination_aclk,
    input  logic                   destination_areset_n,
    input  cdc_fifo_pkg::pointer_t source_pointer,
    output cdc_fifo_pkg::pointer_t destination_pointer
);

    cdc_fifo_pkg::pointer_t gray_source;  // Glitch-free source register
    cdc_fifo_pkg::pointer_t gray_stage_1; // First destination flop, may go metastable
    cdc_fifo_pkg::pointer_t gray_stage_2; // Settled Gray value

    // Gray back to binary, each bit is the XOR of all higher Gray bits
    function automatic cdc_fifo_pkg::pointer_t gray_to_binary(cdc_fifo_pkg::pointer_t gray);
        cdc_fifo_pkg::pointer_t binary;
        binary[cdc_fifo_pkg::ADDRESS_WIDTH-1] = gray[cdc_fifo_pkg::ADDRESS_WIDTH-1];
        for (int i = cdc_fifo_pkg::ADDRESS_WIDTH - 2; i >= 0; i--) begin
            binary[i] = binary[i+1] ^ gray[i];
        end
        return binary;
    endfunction

    // Registered encode, no combinational logic in front of the crossing
    always_ff @(posedge source_aclk or negedge source_areset_n) begin
        if (!source_areset_n) begin
            gray_source <= '0;
        end else begin
            gray_source <= source_pointer ^ (source_pointer >> 1);
        end
    end

    always_ff @(posedge destination_aclk or negedge destination_areset_n) begin
        if (!destination_areset_n) begin
            gray_stage_1 <= '0;
            gray_stage_2 <= '0;
        end else begin
            gray_stage_1 <= gray_source;  // Crossing point
            gray_stage_2 <= gray_stage_1;
        end
    end

    assign destination_pointer = gray_to_binary(gray_stage_2);

endmodule

//--- hw/cdc_fifo_memory.sv
/*
 * Storage array of the dual-clock FIFO.
 * Written in the write clock from a write request, read combinationally at
 * the read pointer. The read controller registers the word itself, so the
 * asynchronous read path ends in the tx domain.
 */
`timescale 1ns/1ps

module cdc_fifo_memory (
    input  logic                                rx_aclk,
    input  cdc_fifo_pkg::write_request_t        write_request,
    input  cdc_fifo_pkg::pointer_t              read_pointer,
    output logic [cdc_fifo_pkg::DATA_WIDTH-1:0] read_data
);

    // One word per slot, contents undefined until written
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] memory [cdc_fifo_pkg::DEPTH];

    always_ff @(posedge rx_aclk) begin
        if (write_request.enable) begin
            memory[write_request.pointer] <= write_request.data;
        end
    end

    // Slot at read_pointer is stable while the reader uses it
    assign read_data = memory[read_pointer];

endmodule

//--- hw/cdc_fifo.sv
/*
 * Dual-clock FIFO top level.
 * Words enter on the rx valid/ready pair in the rx_aclk domain and leave on
 * the tx valid/ready pair in the tx_aclk domain. Each domain has its own
 * asynchronous active-low reset; assert both together.
 */
`timescale 1ns/1ps

module cdc_fifo (
    // Write domain
    input  logic                                rx_aclk,
    input  logic                                rx_areset_n,
    input  logic                                rx_tvalid,
    input  logic [cdc_fifo_pkg::DATA_WIDTH-1:0] rx_tdata,
    output logic                                rx_tready,
    // Read domain
    input  logic                                tx_aclk,
    input  logic                                tx_areset_n,
    output logic                                tx_tvalid,
    output logic [cdc_fifo_pkg::DATA_WIDTH-1:0] tx_tdata,
    input  logic                                tx_tready
);

    cdc_fifo_pkg::write_request_t        write_request;
    cdc_fifo_pkg::pointer_t              write_pointer;        // rx domain
    cdc_fifo_pkg::pointer_t              write_pointer_synced; // In tx domain
    cdc_fifo_pkg::pointer_t              read_pointer;         // tx domain
    cdc_fifo_pkg::pointer_t              read_pointer_synced;  // In rx domain
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] read_data;

    cdc_fifo_write i_write (
        .rx_aclk             (rx_aclk),
        .rx_areset_n         (rx_areset_n),
        .rx_tvalid           (rx_tvalid),
        .rx_tdata            (rx_tdata),
        .rx_tready           (rx_tready),
        .write_request       (write_request),
        .write_pointer       (write_pointer),
        .read_pointer_synced (read_pointer_synced)
    );

    cdc_fifo_memory i_memory (
        .rx_aclk       (rx_aclk),
        .write_request (write_request),
        .read_pointer  (read_pointer),
        .read_data     (read_data)
    );

    cdc_fifo_read i_read (
        .tx_aclk              (tx_aclk),
        .tx_areset_n          (tx_areset_n),
        .tx_tvalid            (tx_tvalid),
        .tx_tdata             (tx_tdata),
        .tx_tready            (tx_tready),
        .read_pointer         (read_pointer),
        .read_data            (read_data),
        .write_pointer_synced (write_pointer_synced)
    );

    // Write pointer into the tx domain
    cdc_fifo_pointer_sync i_write_pointer_sync (
        .source_aclk          (rx_aclk),
        .source_areset_n      (rx_areset_n),
        .destination_aclk     (tx_aclk),
        .destination_areset_n (tx_areset_n),
        .source_pointer       (write_pointer),
        .destination_pointer  (write_pointer_synced)
    );

    // Read pointer back into the rx domain
    cdc_fifo_pointer_sync i_read_pointer_sync (
        .source_aclk          (tx_aclk),
        .source_areset_n      (tx_areset_n),
        .destination_aclk     (rx_aclk),
        .destination_areset_n (rx_areset_n),
        .source_pointer       (read_pointer),
        .destination_pointer  (read_pointer_synced)
    );

endmodule

//--- test/cdc_fifo_checker.sv
/*
 * Handshake and pointer assertions for the dual-clock FIFO.
 * Bound once into the write controller and once into the read controller.
 * The overrun rule only sees write requests on the write side.
 */
`timescale 1ns/1ps

module cdc_fifo_checker (
    input logic                                aclk,
    input logic                                areset_n,
    input logic                                valid,
    input logic                                ready,
    input logic [cdc_fifo_pkg::DATA_WIDTH-1:0] data,
    input logic                                write_enable,        // Low on the read side
    input cdc_fifo_pkg::pointer_t              write_slot,
    input cdc_fifo_pkg::pointer_t              read_pointer_synced
);

    cdc_fifo_pkg::pointer_t write_pointer_after; // Write pointer once this request lands

    assign write_pointer_after = write_slot + 1'b1;

    // Stalled word keeps valid and data until it is taken
    assert_stall_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        valid && !ready |=> valid && $stable(data))
        else $error("Stalled word changed before it was taken");

    // A valid word never carries unknown bits
    assert_known_data: assert property (@(posedge aclk) disable iff (!areset_n)
        valid |-> !$isunknown(data))
        else $error("Valid word has unknown data bits");

    // Equal pointers would read as empty, so at most DEPTH-1 ahead
    assert_no_overrun: assert property (@(posedge aclk) disable iff (!areset_n)
        write_enable |-> write_pointer_after != read_pointer_synced)
        else $error("Write pointer caught up with the synchronized read pointer");

endmodule

bind cdc_fifo_write cdc_fifo_checker i_write_checker (
    .aclk                (rx_aclk),
    .areset_n            (rx_areset_n),
    .valid               (rx_tvalid),
    .ready               (rx_tready),
    .data                (rx_tdata),
    .write_enable        (write_request.enable),
    .write_slot          (write_request.pointer),
    .read_pointer_synced (read_pointer_synced)
);

bind cdc_fifo_read cdc_fifo_checker i_read_checker (
    .aclk                (tx_aclk),
    .areset_n            (tx_areset_n),
    .valid               (tx_tvalid),
    .ready               (tx_tready),
    .data                (tx_tdata),
    .write_enable        (1'b0),
    .write_slot          (cdc_fifo_pkg::pointer_t'(0)),
    .read_pointer_synced (cdc_fifo_pkg::pointer_t'(0))
);

//--- test/cdc_fifo_tb.sv
/*
 * Testbench for the dual-clock FIFO.
 * Pushes a table of traffic patterns through cdc_fifo with unrelated rx and
 * tx clocks. Every accepted word goes into a queue scoreboard and is compared
 * with what leaves the tx port. One result line per test, then the totals.
 */
`timescale 1ns/1ps

module cdc_fifo_tb;

    // One row of the stimulus table
    typedef struct packed {
        int unsigned word_count;    // Words to pass through
        int unsigned write_percent; // Chance of raising rx_tvalid in a free cycle
        int unsigned read_percent;  // Chance of tx_tready per tx cycle
        int unsigned stall_cycles;  // tx cycles with tx_tready low before reading
    } test_row_t;

    logic                                rx_aclk;
    logic                                rx_areset_n;
    logic                                rx_tvalid;
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] rx_tdata;
    logic                                rx_tready;
    logic                                tx_aclk;
    logic                                tx_areset_n;
    logic                                tx_tvalid;
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] tx_tdata;
    logic                                tx_tready;

    test_row_t                           test_table [7];
    logic [cdc_fifo_pkg::DATA_WIDTH-1:0] expected_words [$]; // Oldest word first
    int   error_count;   // Errors in the running test
    int   total_errors;
    int   passed_tests;
    int   failed_tests;
    int   cycle_count;   // rx cycles since time zero
    int   cycle_limit;
    logic stall_active;  // Read side holds tx_tready low
    logic ready_dropped; // rx_tready seen low during the stall
    int   stall_accepts; // Words taken in the stall before ready dropped

    cdc_fifo i_dut (
        .rx_aclk     (rx_aclk),
        .rx_areset_n (rx_areset_n),
        .rx_tvalid   (rx_tvalid),
        .rx_tdata    (rx_tdata),
        .rx_tready   (rx_tready),
        .tx_aclk     (tx_aclk),
        .tx_areset_n (tx_areset_n),
        .tx_tvalid   (tx_tvalid),
        .tx_tdata    (tx_tdata),
        .tx_tready   (tx_tready)
    );

    always #2 rx_aclk = ~rx_aclk; // 4 ns
    always #3 tx_aclk = ~tx_aclk; // 6 ns, unrelated to rx

    // Run limit from the table length
    always @(posedge rx_aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d rx cycles, the tests did not finish", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Roughly 8 rx cycles per word at the slowest rates, plus slack for reset and stalls
    function automatic int timeout_limit();
        int words;
        words = 0;
        foreach (test_table[i]) begin
            words += test_table[i].word_count;
        end
        return words * 8 + 500;
    endfunction

    // Rows that must push the FIFO to its limit while the reader waits
    function automatic bit fills_during_stall(input test_row_t row);
        return row.write_percent == 100 && row.stall_cycles >= 40 &&
               row.word_count > cdc_fifo_pkg::DEPTH;
    endfunction

    task automatic report_mismatch(input string text);
        $display("CHECK FAILED at %0t ns: %s", $time, text);
        error_count++;
    endtask

    task automatic report_problem(input string text);
        $display("ERROR at %0t ns: %s", $time, text);
        error_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == 0) begin
            $display("%s: ok", name);
            passed_tests++;
        end else begin
            $display("%s: %0d errors", name, error_count);
            failed_tests++;
        end
        total_errors += error_count;
    endtask

    // Compare one delivered word with the oldest accepted one
    task automatic take_word(input logic [cdc_fifo_pkg::DATA_WIDTH-1:0] data);
        logic [cdc_fifo_pkg::DATA_WIDTH-1:0] expected;
        if (expected_words.size() == 0) begin
            report_problem("tx port delivered a word that was never written");
        end else begin
            expected = expected_words.pop_front();
            if (data !== expected) begin
                report_mismatch($sformatf("tx_tdata is %h, expected %h", data, expected));
            end
        end
    endtask

    // rx side source, valid held until the word is taken
    task automatic write_words(input test_row_t row);
        int unsigned accepted;
        logic        ready_seen;  // rx_tready as the DUT samples it at the next edge
        logic [31:0] random_word;
        accepted   = 0;
        ready_seen = 1'b0;
        while (accepted < row.word_count) begin
            @(posedge rx_aclk);
            #1;
            if (rx_tvalid && ready_seen) begin // Handshake on the edge just passed
                expected_words.push_back(rx_tdata);
                accepted++;
                rx_tvalid = 1'b0;
                if (stall_active && !ready_dropped) begin
                    stall_accepts++;
                end
            end
            if (stall_active && !rx_tready) begin
                ready_dropped = 1'b1;
            end
            if (!rx_tvalid && accepted < row.word_count &&
                ($urandom % 100) < row.write_percent) begin
                random_word = $urandom;
                rx_tvalid   = 1'b1;
                rx_tdata    = random_word[cdc_fifo_pkg::DATA_WIDTH-1:0];
            end
            ready_seen = rx_tready; // Stable until the next edge
        end
    endtask

    // tx side sink, optional stall first
    task automatic read_words(input test_row_t row);
        int unsigned                         received;
        logic                                valid_seen;
        logic [cdc_fifo_pkg::DATA_WIDTH-1:0] data_seen;
        received   = 0;
        valid_seen = 1'b0;
        data_seen  = '0;
        repeat (row.stall_cycles) @(posedge tx_aclk);
        #1;
        stall_active = 1'b0;
        while (received < row.word_count) begin
            @(posedge tx_aclk);
            #1;
            if (valid_seen && tx_tready) begin // Word taken on the edge just passed
                take_word(data_seen);
                received++;
            end
            tx_tready  = (received < row.word_count) && (($urandom % 100) < row.read_percent);
            valid_seen = tx_tvalid;
            data_seen  = tx_tdata;
        end
    endtask

    // Empty FIFO stays quiet and opens up again for the writer
    task automatic check_drained();
        int waited;
        waited = 0;
        repeat (10) begin
            @(posedge tx_aclk);
            #1;
            if (tx_tvalid) begin
                report_problem("tx_tvalid high after every word was read");
            end
        end
        @(posedge rx_aclk);
        #1;
        while (!rx_tready && waited < 20) begin
            @(posedge rx_aclk);
            #1;
            waited++;
        end
        if (!rx_tready) begin
            report_problem("rx_tready did not return high after the FIFO drained");
        end
    endtask

    initial begin
        void'($urandom(32'h2bb9_b0c3));
        rx_aclk       = 1'b0;
        tx_aclk       = 1'b0;
        rx_areset_n   = 1'b0;
        tx_areset_n   = 1'b0;
        rx_tvalid     = 1'b0;
        rx_tdata      = '0;
        tx_tready     = 1'b0;
        error_count   = 0;
        total_errors  = 0;
        passed_tests  = 0;
        failed_tests  = 0;
        cycle_count   = 0;
        stall_active  = 1'b0;
        ready_dropped = 1'b0;
        stall_accepts = 0;

        // words, write %, read %, stall
        test_table = '{
            '{20, 100, 100,  0},  // Full rate both sides
            '{60,  50,  50,  0},  // Random both sides
            '{40,  30,  90,  0},  // Slow writer
            '{40,  90,  30,  0},  // Slow reader
            '{24, 100, 100, 60},  // Fill during a long stall, then drain
            '{30, 100,  40, 80},  // Fill, then drain slowly
            '{40, 100, 100,  0}   // Burst longer than DEPTH after a drain
        };
        cycle_limit = timeout_limit();

        // Both resets together for 4 rx cycles
        repeat (4) @(posedge rx_aclk);
        #1;
        if (rx_tready || tx_tvalid) begin
            report_mismatch("rx_tready or tx_tvalid high during reset");
        end
        rx_areset_n = 1'b1;
        tx_areset_n = 1'b1;
        repeat (5) begin
            @(posedge tx_aclk);
            #1;
            if (tx_tvalid) begin
                report_problem("tx_tvalid rose with nothing written");
            end
        end
        end_test("Reset");

        for (int t = 0; t < $size(test_table); t++) begin
            error_count   = 0;
            stall_active  = (test_table[t].stall_cycles != 0);
            ready_dropped = 1'b0;
            stall_accepts = 0;
            fork
                write_words(test_table[t]);
                read_words(test_table[t]);
            join
            check_drained();
            if (fills_during_stall(test_table[t]) && !ready_dropped) begin
                report_problem("rx_tready never dropped while the read side was stalled");
            end
            // Memory holds DEPTH-1 words, one more waits in the tx output register
            if (stall_accepts > cdc_fifo_pkg::DEPTH) begin
                report_mismatch($sformatf("%0d words accepted during the stall", stall_accepts));
            end
            end_test($sformatf("Test %0d (%0d words, write %0d%%, read %0d%%, stall %0d)",
                               t, test_table[t].word_count, test_table[t].write_percent,
                               test_table[t].read_percent, test_table[t].stall_cycles));
        end

        $display("Totals: %0d tests passed, %0d tests failed, %0d errors",
                 passed_tests, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/cdc_fifo_pkg.sv
hw/cdc_fifo_write.sv
hw/cdc_fifo_read.sv
hw/cdc_fifo_pointer_sync.sv
hw/cdc_fifo_memory.sv
hw/cdc_fifo.sv
test/cdc_fifo_checker.sv
test/cdc_fifo_tb.sv

//--- Bender.yml
package:
  name: cdc_fifo

sources:
  # RTL in compile order
  - hw/cdc_fifo_pkg.sv
  - hw/cdc_fifo_write.sv
  - hw/cdc_fifo_read.sv
  - hw/cdc_fifo_pointer_sync.sv
  - hw/cdc_fifo_memory.sv
  - hw/cdc_fifo.sv
  # Simulation only
  - target: test
    files:
      - test/cdc_fifo_checker.sv
      - test/cdc_fifo_tb.sv
